//--- verilog/alu_pkg.sv
/*
 * Shared definitions for the iterative arithmetic unit
 * Operand and counter widths, payload types, operation code
 */

`default_nettype none

package alu_pkg;

  // Operand and result width
  localparam int DATA_WIDTH = 16;

  // Iteration counter counting DATA_WIDTH-1 down to 0
  localparam int COUNT_WIDTH = 4;

  // One operand or result
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Double width register for the shift-add and long-division loops
  typedef logic [2*DATA_WIDTH-1:0] wide_t;

  // Operation select as seen on the input port
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,  // a + b
    OP_SUB = 2'd1,  // a - b
    OP_MUL = 2'd2,  // low half of a * b
    OP_DIV = 2'd3   // quotient of a / b
  } alu_op_e;

endpackage

`default_nettype wire

//--- verilog/alu_req_if.sv
/*
 * Request bundle from operand capture to the processing core
 * Captured operands, operation, sign mode, start pulse
 */

`default_nettype none

interface alu_req_if;

  logic             start;      // One cycle, after acceptance
  alu_pkg::data_t   a;          // Held until the next acceptance
  alu_pkg::data_t   b;
  alu_pkg::alu_op_e op;
  logic             is_signed;
  logic             div_zero;   // Division with b == 0
  logic             quot_neg;   // Signed division, operand signs differ

  // Producer side
  modport capture (output start, a, b, op, is_signed, div_zero, quot_neg);

  // Sequencer and datapath side
  modport core (input start, a, b, op, is_signed, div_zero, quot_neg);

endinterface

`default_nettype wire

//--- verilog/alu_ctrl_if.sv
/*
 * Per-cycle datapath commands from the sequencer
 * Operand status flags coming back from the datapath
 */

`default_nettype none

interface alu_ctrl_if;

  // Commands, each one applies at the next rising edge
  logic load;      // Load A and B, clear result
  logic do_add;    // result = a + b
  logic do_sub;    // result = a - b
  logic flip_a;    // Negate A if negative
  logic flip_b;    // Negate B if negative
  logic do_mul;    // One shift-add step
  logic do_div;    // One long-division step
  logic fix_sign;  // Negate the quotient

  // Status back from the datapath
  logic a_neg;     // Sign bit of the A operand
  logic b_neg;     // Sign bit of the B operand
  logic mul_bit;   // Current multiplier LSB

  modport seq (
    output load, do_add, do_sub, flip_a, flip_b, do_mul, do_div, fix_sign,
    input  a_neg, b_neg, mul_bit
  );

  modport dp (
    input  load, do_add, do_sub, flip_a, flip_b, do_mul, do_div, fix_sign,
    output a_neg, b_neg, mul_bit
  );

endinterface

`default_nettype wire

//--- verilog/alu_operand_capture.sv
/*
 * Input side of the arithmetic unit
 * Valid/ready handshake, operand registers, start pulse,
 * divide-by-zero and quotient sign detection
 */

`default_nettype none

module alu_operand_capture (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire alu_pkg::data_t   i_a,
  input  wire alu_pkg::data_t   i_b,
  input  wire alu_pkg::alu_op_e i_op,
  input  wire logic             i_signed,
  input  wire logic             i_valid,
  input  wire logic             i_release,  // Result taken downstream
  output logic                  o_ready,
  alu_req_if.capture            req
);

  logic busy_q;  // One operation in flight
  logic accept;

  assign o_ready = !busy_q;
  assign accept  = i_valid && !busy_q;

  // Busy from acceptance until the result buffer lets go
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      req.start <= 1'b0;
    end else begin
      req.start <= accept;  // Kicks off the sequencer
      if (accept) begin
        busy_q <= 1'b1;
      end else if (i_release) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operand snapshot, stays put until next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req.a         <= i_a;
      req.b         <= i_b;
      req.op        <= i_op;
      req.is_signed <= i_signed;
      req.div_zero  <= (i_op == alu_pkg::OP_DIV) && (i_b == '0);
      // Quotient gets negated later when signs differ
      req.quot_neg  <= i_signed && (i_op == alu_pkg::OP_DIV) &&
                       (i_a[alu_pkg::DATA_WIDTH-1] ^ i_b[alu_pkg::DATA_WIDTH-1]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu_sequencer.sv
/*
 * Operation sequencer
 * FSM that issues one datapath command per cycle, plus the
 * iteration counter for the multiply and divide loops
 */

`default_nettype none

module alu_sequencer (
  input  wire logic clk,
  input  wire logic rst_n,
  alu_req_if.core   req,
  alu_ctrl_if.seq   ctrl,
  output logic      o_done,        // One cycle, result is ready
  output logic      o_done_error   // Qualifies o_done, divide by zero
);

  typedef logic [alu_pkg::COUNT_WIDTH-1:0] count_t;

  typedef enum logic [3:0] {
    IDLE,
    LOAD,
    ADD,
    SUB,
    MUL,
    FLIP_A,
    FLIP_B,
    DIV,
    FIX_SIGN,
    DONE
  } seq_state_e;

  seq_state_e state_q;
  seq_state_e state_d;
  count_t     cnt_q;
  logic       last_step;  // Final loop iteration

  assign last_step = (cnt_q == '0);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req.start) begin
          if (req.div_zero) begin
            state_d = DONE;  // Nothing to compute
          end else begin
            case (req.op)
              alu_pkg::OP_ADD: state_d = ADD;
              alu_pkg::OP_SUB: state_d = SUB;
              default:         state_d = LOAD;  // MUL and DIV need the wide regs
            endcase
          end
        end
      end
      LOAD: begin
        if (req.op == alu_pkg::OP_MUL) begin
          state_d = MUL;
        end else begin
          state_d = req.is_signed ? FLIP_A : DIV;  // Unsigned skips the flips
        end
      end
      ADD, SUB: state_d = DONE;
      MUL:      state_d = last_step ? DONE : MUL;
      FLIP_A:   state_d = FLIP_B;
      FLIP_B:   state_d = DIV;
      DIV: begin
        if (last_step) begin
          state_d = req.is_signed ? FIX_SIGN : DONE;
        end
      end
      FIX_SIGN: state_d = DONE;
      DONE:     state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      cnt_q   <= count_t'(alu_pkg::DATA_WIDTH - 1);
    end else begin
      state_q <= state_d;
      if ((state_q == MUL) || (state_q == DIV)) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        cnt_q <= count_t'(alu_pkg::DATA_WIDTH - 1);  // Rearm outside the loops
      end
    end
  end

  // Commands decoded from state only
  assign ctrl.load     = (state_q == LOAD);
  assign ctrl.do_add   = (state_q == ADD);
  assign ctrl.do_sub   = (state_q == SUB);
  assign ctrl.do_mul   = (state_q == MUL);
  assign ctrl.flip_a   = (state_q == FLIP_A);
  assign ctrl.flip_b   = (state_q == FLIP_B);
  assign ctrl.do_div   = (state_q == DIV);
  assign ctrl.fix_sign = (state_q == FIX_SIGN) && req.quot_neg;  // Idle slot otherwise

  assign o_done       = (state_q == DONE);
  assign o_done_error = (state_q == DONE) && req.div_zero;

endmodule

`default_nettype wire

//--- verilog/alu_datapath.sv
/*
 * Arithmetic datapath around one shared adder
 * A, B and result registers, add/sub, negation,
 * shift-and-add multiply and restoring division steps
 */

`default_nettype none

module alu_datapath (
  input  wire logic      clk,
  input  wire logic      rst_n,
  alu_req_if.core        req,      // Only a and b are read
  alu_ctrl_if.dp         ctrl,
  output alu_pkg::data_t o_result
);

  localparam int W = alu_pkg::DATA_WIDTH;

  alu_pkg::wide_t a_q;     // {remainder, dividend} or multiplier
  alu_pkg::data_t b_q;     // Divisor or shifting multiplicand
  alu_pkg::data_t res_q;   // Result, product or quotient

  // Shared adder, x + (inv ? ~y : y) + inv
  alu_pkg::data_t add_x;
  alu_pkg::data_t add_y;
  logic           add_inv;
  logic [W:0]     add_sum;  // Carry out on top
  logic           divides;  // Trial subtract did not borrow

  assign add_sum = {1'b0, add_x} + {1'b0, (add_inv ? ~add_y : add_y)} + {{W{1'b0}}, add_inv};

  // Shifted remainder may reach 17 bits; the top bit set always fits
  assign divides = add_sum[W] | a_q[2*W-1];

  assign ctrl.a_neg   = a_q[W-1];
  assign ctrl.b_neg   = b_q[W-1];
  assign ctrl.mul_bit = a_q[0];

  // Adder operand select
  always_comb begin
    add_x   = '0;
    add_y   = '0;
    add_inv = 1'b0;
    if (ctrl.do_add) begin
      add_x = req.a;
      add_y = req.b;
    end else if (ctrl.do_sub) begin
      add_x   = req.a;
      add_y   = req.b;
      add_inv = 1'b1;
    end else if (ctrl.flip_a) begin
      add_y   = a_q[W-1:0];  // 0 - a
      add_inv = 1'b1;
    end else if (ctrl.flip_b) begin
      add_y   = b_q;         // 0 - b
      add_inv = 1'b1;
    end else if (ctrl.do_mul) begin
      add_x = res_q;         // Accumulate partial product
      add_y = b_q;
    end else if (ctrl.do_div) begin
      add_x   = a_q[2*W-2:W-1];  // Remainder after the left shift
      add_y   = b_q;
      add_inv = 1'b1;
    end else if (ctrl.fix_sign) begin
      add_y   = res_q;       // 0 - quotient
      add_inv = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      res_q <= '0;
    end else begin
      if (ctrl.load) begin
        a_q   <= {{W{1'b0}}, req.a};  // Zero upper half
        b_q   <= req.b;
        res_q <= '0;
      end else if (ctrl.do_add || ctrl.do_sub) begin
        res_q <= add_sum[W-1:0];  // Wraps modulo 2^W
      end else if (ctrl.flip_a) begin
        if (ctrl.a_neg) a_q[W-1:0] <= add_sum[W-1:0];
      end else if (ctrl.flip_b) begin
        if (ctrl.b_neg) b_q <= add_sum[W-1:0];
      end else if (ctrl.do_mul) begin
        if (ctrl.mul_bit) res_q <= add_sum[W-1:0];
        a_q[W-1:0] <= {1'b0, a_q[W-1:1]};  // Next multiplier bit
        b_q        <= {b_q[W-2:0], 1'b0};  // Multiplicand weight x2
      end else if (ctrl.do_div) begin
        if (divides) begin
          a_q <= {add_sum[W-1:0], a_q[W-2:0], 1'b0};  // Keep difference
        end else begin
          a_q <= {a_q[2*W-2:0], 1'b0};  // Restore, shift only
        end
        res_q <= {res_q[W-2:0], divides};  // Quotient bit in
      end else if (ctrl.fix_sign) begin
        res_q <= add_sum[W-1:0];
      end
    end
  end

  assign o_result = res_q;

endmodule

`default_nettype wire

//--- verilog/alu_result_buffer.sv
/*
 * Output side of the arithmetic unit
 * Result and error holding registers, valid/ready handshake,
 * release pulse back to operand capture
 */

`default_nettype none

module alu_result_buffer (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            i_done,
  input  wire logic            i_done_error,
  input  wire alu_pkg::data_t  i_result,
  input  wire logic            i_result_ready,
  output alu_pkg::data_t       o_result,
  output logic                 o_error,
  output logic                 o_result_valid,
  output logic                 o_release       // Handshake completes this cycle
);

  logic           valid_q;
  logic           error_q;
  alu_pkg::data_t result_q;

  // Handshake done when both sides agree
  assign o_release = valid_q && i_result_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else if (i_done) begin
      valid_q <= 1'b1;
      error_q <= i_done_error;
    end else if (o_release) begin
      valid_q <= 1'b0;  // Error flag just goes stale
    end
  end

  // Error result defined as zero
  always_ff @(posedge clk) begin
    if (i_done) begin
      result_q <= i_done_error ? '0 : i_result;
    end
  end

  assign o_result       = result_q;
  assign o_error        = error_q;
  assign o_result_valid = valid_q;

endmodule

`default_nettype wire

//--- verilog/alu_top.sv
/*
 * Top level of the multi-cycle 16-bit arithmetic unit
 * Capture, sequencer, datapath and result buffer hookup
 */

`default_nettype none

module alu_top (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire alu_pkg::data_t   i_a,
  input  wire alu_pkg::data_t   i_b,
  input  wire alu_pkg::alu_op_e i_op,
  input  wire logic             i_signed,
  input  wire logic             i_valid,
  output logic                  o_ready,
  output alu_pkg::data_t        o_result,
  output logic                  o_error,
  output logic                  o_result_valid,
  input  wire logic             i_result_ready
);

  alu_req_if  req ();
  alu_ctrl_if ctrl ();

  logic           done;
  logic           done_error;
  logic           release_pulse;
  alu_pkg::data_t dp_result;  // Raw datapath result

  alu_operand_capture u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_a       (i_a),
    .i_b       (i_b),
    .i_op      (i_op),
    .i_signed  (i_signed),
    .i_valid   (i_valid),
    .i_release (release_pulse),
    .o_ready   (o_ready),
    .req       (req.capture)
  );

  alu_sequencer u_sequencer (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req.core),
    .ctrl         (ctrl.seq),
    .o_done       (done),
    .o_done_error (done_error)
  );

  alu_datapath u_datapath (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req.core),
    .ctrl     (ctrl.dp),
    .o_result (dp_result)
  );

  alu_result_buffer u_result_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_done         (done),
    .i_done_error   (done_error),
    .i_result       (dp_result),
    .i_result_ready (i_result_ready),
    .o_result       (o_result),
    .o_error        (o_error),
    .o_result_valid (o_result_valid),
    .o_release      (release_pulse)
  );

endmodule

`default_nettype wire

//--- verification/alu_checker.sv
/*
 * Handshake assertions for the arithmetic unit, bound into alu_top
 * Ready/valid exclusion, output hold under back-pressure,
 * ready right after reset
 */

`default_nettype none

module alu_checker (
  input wire logic           clk,
  input wire logic           rst_n,
  input wire logic           i_ready,         // DUT o_ready
  input wire alu_pkg::data_t i_result,        // DUT o_result
  input wire logic           i_error,         // DUT o_error
  input wire logic           i_result_valid,  // DUT o_result_valid
  input wire logic           i_result_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // One operation in flight, so no new slot while a result waits
  ready_valid_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(i_result_valid && i_ready)
  ) else $error("o_result_valid and o_ready are high together");

  // Stalled result must not move
  result_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (i_result_valid && !i_result_ready) |=> ($stable(i_result) && $stable(i_error))
  ) else $error("o_result or o_error changed while the result was stalled");

  ready_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> i_ready  // First cycle out of reset
  ) else $error("o_ready is low in the first cycle after reset");

endmodule

bind alu_top alu_checker u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .i_ready        (o_ready),
  .i_result       (o_result),
  .i_error        (o_error),
  .i_result_valid (o_result_valid),
  .i_result_ready (i_result_ready)
);

`default_nettype wire

//--- verification/alu_tb.sv
/*
 * Testbench for the multi-cycle arithmetic unit
 * Directed and random operation table, reference model,
 * random back-pressure on the result side, watchdog
 */

`default_nettype none

module alu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 5;
  localparam int          NUM_DIRECTED = 16;
  localparam int          NUM_RANDOM   = 40;
  localparam int          NUM_ENTRIES  = NUM_DIRECTED + NUM_RANDOM;
  localparam int          MAX_LATENCY  = 24;  // Acceptance to o_result_valid
  localparam logic [31:0] SEED         = 32'h63d2_8e2b;
  localparam int          TIMEOUT_NS   = (NUM_ENTRIES * 40 + RESET_CYCLES) * CLK_PERIOD;

  logic             clk = 1'b0;
  logic             rst_n;
  alu_pkg::data_t   i_a;
  alu_pkg::data_t   i_b;
  alu_pkg::alu_op_e i_op;
  logic             i_signed;
  logic             i_valid;
  logic             i_result_ready;
  logic             o_ready;
  alu_pkg::data_t   o_result;
  logic             o_error;
  logic             o_result_valid;

  // Stimulus and expected values with one row per operation
  alu_pkg::alu_op_e op_tbl  [NUM_ENTRIES];
  logic             sgn_tbl [NUM_ENTRIES];
  alu_pkg::data_t   a_tbl   [NUM_ENTRIES];
  alu_pkg::data_t   b_tbl   [NUM_ENTRIES];
  alu_pkg::data_t   res_tbl [NUM_ENTRIES];
  logic             err_tbl [NUM_ENTRIES];

  logic [31:0] lcg_state;
  int          error_count;

  alu_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_a            (i_a),
    .i_b            (i_b),
    .i_op           (i_op),
    .i_signed       (i_signed),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .o_result       (o_result),
    .o_error        (o_error),
    .o_result_valid (o_result_valid),
    .i_result_ready (i_result_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
  endfunction

  // Arithmetic rules of the unit returning {error, result}
  function automatic logic [alu_pkg::DATA_WIDTH:0] reference_result(
    input alu_pkg::alu_op_e op,
    input logic             sgn,
    input alu_pkg::data_t   a,
    input alu_pkg::data_t   b
  );
    alu_pkg::wide_t prod;
    alu_pkg::data_t mag_a;
    alu_pkg::data_t mag_b;
    alu_pkg::data_t quot;
    prod  = alu_pkg::wide_t'(a) * alu_pkg::wide_t'(b);
    mag_a = (sgn && a[alu_pkg::DATA_WIDTH-1]) ? -a : a;  // Magnitudes in signed mode
    mag_b = (sgn && b[alu_pkg::DATA_WIDTH-1]) ? -b : b;
    quot  = '0;
    if ((op == alu_pkg::OP_DIV) && (b != '0)) begin
      quot = mag_a / mag_b;
      if (sgn && (a[alu_pkg::DATA_WIDTH-1] ^ b[alu_pkg::DATA_WIDTH-1])) quot = -quot;
    end
    case (op)
      alu_pkg::OP_ADD: return {1'b0, alu_pkg::data_t'(a + b)};  // Wraps
      alu_pkg::OP_SUB: return {1'b0, alu_pkg::data_t'(a - b)};
      alu_pkg::OP_MUL: return {1'b0, prod[alu_pkg::DATA_WIDTH-1:0]};
      default:         return {(b == '0), quot};  // Zero result on error
    endcase
  endfunction

  task automatic set_row(input int idx, input alu_pkg::alu_op_e op, input logic sgn,
                         input alu_pkg::data_t a, input alu_pkg::data_t b,
                         input alu_pkg::data_t res, input logic err);
    op_tbl[idx]  = op;
    sgn_tbl[idx] = sgn;
    a_tbl[idx]   = a;
    b_tbl[idx]   = b;
    res_tbl[idx] = res;
    err_tbl[idx] = err;
  endtask

  task automatic build_table();
    alu_pkg::alu_op_e op;
    logic             sgn;
    alu_pkg::data_t   a;
    alu_pkg::data_t   b;
    alu_pkg::data_t   res;
    logic             err;
    set_row(0,  alu_pkg::OP_ADD, 1'b0, 16'hFFFF, 16'h0001, 16'h0000, 1'b0);  // Wrap up
    set_row(1,  alu_pkg::OP_SUB, 1'b0, 16'h0000, 16'h0001, 16'hFFFF, 1'b0);  // Wrap down
    set_row(2,  alu_pkg::OP_ADD, 1'b1, 16'h7FFF, 16'h0001, 16'h8000, 1'b0);
    set_row(3,  alu_pkg::OP_SUB, 1'b1, 16'h1234, 16'h0234, 16'h1000, 1'b0);
    set_row(4,  alu_pkg::OP_MUL, 1'b0, 16'h00FF, 16'h0101, 16'hFFFF, 1'b0);
    set_row(5,  alu_pkg::OP_MUL, 1'b1, 16'hFFFF, 16'hFFFF, 16'h0001, 1'b0);  // Sign ignored
    set_row(6,  alu_pkg::OP_MUL, 1'b0, 16'h1234, 16'h0010, 16'h2340, 1'b0);
    set_row(7,  alu_pkg::OP_DIV, 1'b0, 16'hFFFF, 16'h0003, 16'h5555, 1'b0);
    set_row(8,  alu_pkg::OP_DIV, 1'b0, 16'h0007, 16'h0009, 16'h0000, 1'b0);
    set_row(9,  alu_pkg::OP_DIV, 1'b1, 16'hFFF9, 16'h0002, 16'hFFFD, 1'b0);  // -7 / 2
    set_row(10, alu_pkg::OP_DIV, 1'b1, 16'h0007, 16'hFFFE, 16'hFFFD, 1'b0);  // 7 / -2
    set_row(11, alu_pkg::OP_DIV, 1'b1, 16'hFFF9, 16'hFFFE, 16'h0003, 1'b0);  // -7 / -2
    set_row(12, alu_pkg::OP_DIV, 1'b0, 16'h1234, 16'h0000, 16'h0000, 1'b1);
    set_row(13, alu_pkg::OP_DIV, 1'b1, 16'h8000, 16'h0000, 16'h0000, 1'b1);
    set_row(14, alu_pkg::OP_ADD, 1'b0, 16'h0001, 16'h0002, 16'h0003, 1'b0);  // Recovery
    set_row(15, alu_pkg::OP_DIV, 1'b0, 16'hFFFF, 16'h8001, 16'h0001, 1'b0);
    for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
      lcg_state = next_random(lcg_state);
      op        = alu_pkg::alu_op_e'(lcg_state[31:30]);
      sgn       = lcg_state[29];
      a         = lcg_state[23:8];
      lcg_state = next_random(lcg_state);
      b         = lcg_state[31:16];
      if (lcg_state[15:14] == 2'b00) b = b & 16'h000F;  // Small divisors with an odd zero
      {err, res} = reference_result(op, sgn, a, b);
      set_row(i, op, sgn, a, b, res, err);
    end
  endtask

  // One operation from handshake in to result taken
  task automatic run_entry(input int idx);
    int   latency;
    logic taken;
    while (o_ready !== 1'b1) @(negedge clk);
    i_a      = a_tbl[idx];
    i_b      = b_tbl[idx];
    i_op     = op_tbl[idx];
    i_signed = sgn_tbl[idx];
    i_valid  = 1'b1;
    @(negedge clk);  // Accepted at the edge in between
    i_valid = 1'b0;
    latency = 0;
    taken   = 1'b0;
    while (!taken) begin
      if (o_ready !== 1'b0) begin
        $display("[ERROR] entry %0d: o_ready = %h while busy, expected 0", idx, o_ready);
        error_count++;
      end
      if (o_result_valid !== 1'b1) latency++;
      lcg_state      = next_random(lcg_state);
      i_result_ready = lcg_state[31];  // Random back-pressure
      if ((o_result_valid === 1'b1) && i_result_ready) begin
        if (o_result !== res_tbl[idx]) begin
          $display("[ERROR] entry %0d: o_result = %h, expected %h", idx, o_result, res_tbl[idx]);
          error_count++;
        end
        if (o_error !== err_tbl[idx]) begin
          $display("[ERROR] entry %0d: o_error = %h, expected %h", idx, o_error, err_tbl[idx]);
          error_count++;
        end
        taken = 1'b1;
      end
      @(negedge clk);
    end
    if (latency > MAX_LATENCY) begin
      $display("Entry %0d took %0d cycles to produce a result, limit is %0d",
               idx, latency, MAX_LATENCY);
      error_count++;
    end
    if (o_result_valid !== 1'b0) begin
      $display("[ERROR] entry %0d: o_result_valid = %h after take, expected 0",
               idx, o_result_valid);
      error_count++;
    end
    if (o_ready !== 1'b1) begin
      $display("[ERROR] entry %0d: o_ready = %h after take, expected 1", idx, o_ready);
      error_count++;
    end
  endtask

  initial begin
    rst_n          = 1'b0;
    i_a            = '0;
    i_b            = '0;
    i_op           = alu_pkg::OP_ADD;
    i_signed       = 1'b0;
    i_valid        = 1'b0;
    i_result_ready = 1'b0;
    error_count    = 0;
    lcg_state      = SEED;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (o_ready !== 1'b1) begin
      $display("[ERROR] after reset: o_ready = %h, expected 1", o_ready);
      error_count++;
    end
    if (o_result_valid !== 1'b0) begin
      $display("[ERROR] after reset: o_result_valid = %h, expected 0", o_result_valid);
      error_count++;
    end
    for (int i = 0; i < NUM_ENTRIES; i++) run_entry(i);
    $display("Operations checked: %0d, errors: %0d", NUM_ENTRIES, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Hang guard sized from the table length
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped responding", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
verilog/alu_pkg.sv
verilog/alu_req_if.sv
verilog/alu_ctrl_if.sv
verilog/alu_operand_capture.sv
verilog/alu_sequencer.sv
verilog/alu_datapath.sv
verilog/alu_result_buffer.sv
verilog/alu_top.sv
verification/alu_checker.sv
verification/alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the arithmetic unit testbench with Verilator.
# A failed build or an aborted run also lands the fail message in sim.log.

rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module alu_tb -o alu_sim -f src.f &&
./obj_dir/alu_sim > sim.log 2>&1 ||
echo "Simulation failed" >> sim.log

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
